// File: common/isaPkg.sv
`default_nettype none

package isaPkg;
	typedef logic [15:0] word_t;   // data, address, pc and counter width
	typedef logic [3:0] opcode_t;
	typedef logic [5:0] func_t;
	typedef logic [1:0] regIdx_t;
	typedef logic [3:0] aluOp_t;

	// major opcodes in bits 15:12
	localparam opcode_t OP_BNE = 4'd0;
	localparam opcode_t OP_BEQ = 4'd1;
	localparam opcode_t OP_BGZ = 4'd2;
	localparam opcode_t OP_BLZ = 4'd3;
	localparam opcode_t OP_ADI = 4'd4;
	localparam opcode_t OP_ORI = 4'd5;
	localparam opcode_t OP_LHI = 4'd6;
	localparam opcode_t OP_LWD = 4'd7;
	localparam opcode_t OP_SWD = 4'd8;
	localparam opcode_t OP_JMP = 4'd9;
	localparam opcode_t OP_JAL = 4'd10;
	localparam opcode_t OP_RTYPE = 4'd15;

	// r-type function field
	localparam func_t FUNC_ADD = 6'd0;
	localparam func_t FUNC_SUB = 6'd1;
	localparam func_t FUNC_AND = 6'd2;
	localparam func_t FUNC_ORR = 6'd3;
	localparam func_t FUNC_NOT = 6'd4;
	localparam func_t FUNC_TCP = 6'd5;
	localparam func_t FUNC_SHL = 6'd6;
	localparam func_t FUNC_SHR = 6'd7;
	localparam func_t FUNC_JPR = 6'd25;
	localparam func_t FUNC_JRL = 6'd26;
	localparam func_t FUNC_WWD = 6'd28;
	localparam func_t FUNC_HLT = 6'd29;

	localparam aluOp_t ALU_ADD = 4'd0;
	localparam aluOp_t ALU_SUB = 4'd1;
	localparam aluOp_t ALU_AND = 4'd2;
	localparam aluOp_t ALU_OR = 4'd3;
	localparam aluOp_t ALU_NOT = 4'd4;
	localparam aluOp_t ALU_TCP = 4'd5;    // two's complement
	localparam aluOp_t ALU_ALS = 4'd6;    // shift left by one
	localparam aluOp_t ALU_ARS = 4'd7;    // arithmetic shift right by one
	localparam aluOp_t ALU_ZERO = 4'd8;

	// instruction fields
	function automatic opcode_t opcodeField(word_t instr);
		return instr[15:12];
	endfunction

	function automatic func_t funcField(word_t instr);
		return instr[5:0];
	endfunction

	function automatic regIdx_t rsField(word_t instr);
		return instr[11:10];
	endfunction

	function automatic regIdx_t rtField(word_t instr);
		return instr[9:8];
	endfunction

	function automatic regIdx_t rdField(word_t instr);
		return instr[7:6];
	endfunction

	function automatic logic [7:0] imm8Field(word_t instr);
		return instr[7:0];
	endfunction

	function automatic logic [11:0] target12Field(word_t instr);
		return instr[11:0];
	endfunction

	function automatic word_t signExtend8(logic [7:0] imm);
		return {{8{imm[7]}}, imm};
	endfunction
endpackage

`default_nettype wire

// File: common/cpuPkg.sv
`default_nettype none

package cpuPkg;
	typedef enum logic [2:0] {
		FETCH,
		FETCH_WAIT,
		DECODE,
		EXEC,
		MEM,
		MEM_WAIT,
		WRITEBACK
	} microState_t;

	// writeback source
	typedef logic [1:0] wbSel_t;
	localparam wbSel_t WB_ALU = 2'd0;
	localparam wbSel_t WB_MEMORY = 2'd1;
	localparam wbSel_t WB_LINK = 2'd2;    // pc of next instruction
	localparam wbSel_t WB_UPPER = 2'd3;   // imm8 in the top byte

	// destination register
	typedef logic [1:0] dstSel_t;
	localparam dstSel_t DST_RD = 2'd0;
	localparam dstSel_t DST_RT = 2'd1;
	localparam dstSel_t DST_R2 = 2'd2;    // link register

	// next pc source
	typedef logic [1:0] pcSrc_t;
	localparam pcSrc_t PC_SEQ = 2'd0;
	localparam pcSrc_t PC_BRANCH = 2'd1;
	localparam pcSrc_t PC_JUMP = 2'd2;
	localparam pcSrc_t PC_REG = 2'd3;

	// first fetch rolls the counter over to zero
	localparam isaPkg::word_t NUM_INST_RESET = 16'hffff;
endpackage

`default_nettype wire

// File: control/controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
	input wire clk,
	input wire reset_n,
	input wire isaPkg::word_t instruction,
	input wire fetchDone,
	input wire dataDone,
	input wire branchTaken,
	output cpuPkg::microState_t microState,
	output isaPkg::aluOp_t aluOp,
	output logic aluSrcImm,
	output logic regWrite,
	output cpuPkg::wbSel_t wbSel,
	output cpuPkg::dstSel_t dstSel,
	output cpuPkg::pcSrc_t pcSrc,
	output logic pcWrite,
	output logic irWrite,
	output logic fetchStart,
	output logic dataStart,
	output logic outputStrobe,
	output isaPkg::word_t numInst,
	output logic halted
);
	isaPkg::opcode_t opcode;
	isaPkg::func_t func;
	logic isRtype, isJump, isWwd, isHlt, isJpr, isMemOp, endsInExec;
	logic loadControls;
	cpuPkg::microState_t nextState;

	// decoded controls latched for the whole instruction
	isaPkg::aluOp_t decAluOp;
	logic decAluSrcImm, decWritesReg;
	cpuPkg::wbSel_t decWbSel;
	cpuPkg::dstSel_t decDstSel;
	cpuPkg::pcSrc_t decPcSrc;
	logic writesReg;
	cpuPkg::pcSrc_t heldPcSrc;

	assign opcode = isaPkg::opcodeField(instruction);
	assign func = isaPkg::funcField(instruction);
	assign isRtype = opcode == isaPkg::OP_RTYPE;
	assign isJump = opcode == isaPkg::OP_JMP || opcode == isaPkg::OP_JAL;
	assign isWwd = isRtype && func == isaPkg::FUNC_WWD;
	assign isHlt = isRtype && func == isaPkg::FUNC_HLT;
	assign isJpr = isRtype && func == isaPkg::FUNC_JPR;
	assign isMemOp = opcode == isaPkg::OP_LWD || opcode == isaPkg::OP_SWD;
	assign endsInExec = opcode <= isaPkg::OP_BLZ || opcode == isaPkg::OP_JMP || isWwd || isJpr;

	always_comb begin
		decAluOp = isaPkg::ALU_ZERO;
		decAluSrcImm = 1'b0;
		decWritesReg = 1'b0;
		decWbSel = cpuPkg::WB_ALU;
		decDstSel = cpuPkg::DST_RD;
		decPcSrc = cpuPkg::PC_SEQ;
		case (opcode)
			isaPkg::OP_RTYPE: begin
				decWritesReg = func <= isaPkg::FUNC_SHR;   // alu group only
				case (func)
					isaPkg::FUNC_ADD: decAluOp = isaPkg::ALU_ADD;
					isaPkg::FUNC_SUB: decAluOp = isaPkg::ALU_SUB;
					isaPkg::FUNC_AND: decAluOp = isaPkg::ALU_AND;
					isaPkg::FUNC_ORR: decAluOp = isaPkg::ALU_OR;
					isaPkg::FUNC_NOT: decAluOp = isaPkg::ALU_NOT;
					isaPkg::FUNC_TCP: decAluOp = isaPkg::ALU_TCP;
					isaPkg::FUNC_SHL: decAluOp = isaPkg::ALU_ALS;
					isaPkg::FUNC_SHR: decAluOp = isaPkg::ALU_ARS;
					isaPkg::FUNC_JPR: decPcSrc = cpuPkg::PC_REG;
					isaPkg::FUNC_JRL: begin
						decPcSrc = cpuPkg::PC_REG;
						decWritesReg = 1'b1;
						decWbSel = cpuPkg::WB_LINK;
						decDstSel = cpuPkg::DST_R2;
					end
					default: decAluOp = isaPkg::ALU_ZERO;   // wwd, hlt
				endcase
			end
			isaPkg::OP_ADI, isaPkg::OP_ORI: begin
				decAluOp = (opcode == isaPkg::OP_ADI) ? isaPkg::ALU_ADD : isaPkg::ALU_OR;
				decAluSrcImm = 1'b1;
				decWritesReg = 1'b1;
				decDstSel = cpuPkg::DST_RT;
			end
			isaPkg::OP_LHI: begin
				decWritesReg = 1'b1;
				decWbSel = cpuPkg::WB_UPPER;
				decDstSel = cpuPkg::DST_RT;
			end
			isaPkg::OP_LWD, isaPkg::OP_SWD: begin
				decAluOp = isaPkg::ALU_ADD;   // effective address
				decAluSrcImm = 1'b1;
				decWritesReg = opcode == isaPkg::OP_LWD;
				decWbSel = cpuPkg::WB_MEMORY;
				decDstSel = cpuPkg::DST_RT;
			end
			isaPkg::OP_BNE, isaPkg::OP_BEQ, isaPkg::OP_BGZ, isaPkg::OP_BLZ:
				decPcSrc = cpuPkg::PC_BRANCH;
			isaPkg::OP_JMP: decPcSrc = cpuPkg::PC_JUMP;
			isaPkg::OP_JAL: begin
				decPcSrc = cpuPkg::PC_JUMP;
				decWritesReg = 1'b1;
				decWbSel = cpuPkg::WB_LINK;
				decDstSel = cpuPkg::DST_R2;
			end
			default: decPcSrc = cpuPkg::PC_SEQ;
		endcase
	end

	always_comb begin
		nextState = microState;
		case (microState)
			cpuPkg::FETCH: nextState = cpuPkg::FETCH_WAIT;
			cpuPkg::FETCH_WAIT: begin
				if (fetchDone)
					nextState = isJump ? cpuPkg::EXEC : cpuPkg::DECODE;   // jumps skip decode
			end
			cpuPkg::DECODE: begin
				if (!isHlt)
					nextState = cpuPkg::EXEC;
			end
			cpuPkg::EXEC: begin
				if (isMemOp)
					nextState = cpuPkg::MEM;
				else if (endsInExec)
					nextState = cpuPkg::FETCH;
				else
					nextState = cpuPkg::WRITEBACK;
			end
			cpuPkg::MEM: nextState = cpuPkg::MEM_WAIT;
			cpuPkg::MEM_WAIT: begin
				if (dataDone)
					nextState = (opcode == isaPkg::OP_LWD) ? cpuPkg::WRITEBACK : cpuPkg::FETCH;
			end
			default: nextState = cpuPkg::FETCH;   // writeback
		endcase
	end

	assign loadControls = microState == cpuPkg::DECODE ||
		(microState == cpuPkg::FETCH_WAIT && fetchDone && isJump);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			microState <= cpuPkg::FETCH;
			numInst <= cpuPkg::NUM_INST_RESET;
			halted <= 1'b0;
			aluOp <= isaPkg::ALU_ZERO;
			aluSrcImm <= 1'b0;
			writesReg <= 1'b0;
			wbSel <= cpuPkg::WB_ALU;
			dstSel <= cpuPkg::DST_RD;
			heldPcSrc <= cpuPkg::PC_SEQ;
		end else if (!halted) begin
			microState <= nextState;
			if (microState == cpuPkg::FETCH)
				numInst <= numInst + 16'd1;
			if (microState == cpuPkg::DECODE && isHlt)
				halted <= 1'b1;   // state stays in DECODE from here on
			if (loadControls) begin
				aluOp <= decAluOp;
				aluSrcImm <= decAluSrcImm;
				writesReg <= decWritesReg;
				wbSel <= decWbSel;
				dstSel <= decDstSel;
				heldPcSrc <= decPcSrc;
			end
		end
	end

	// not-taken branch falls back to pc + 1
	assign pcSrc = (heldPcSrc == cpuPkg::PC_BRANCH && !branchTaken) ? cpuPkg::PC_SEQ : heldPcSrc;

	assign fetchStart = microState == cpuPkg::FETCH;
	assign irWrite = microState == cpuPkg::FETCH_WAIT;
	assign dataStart = microState == cpuPkg::MEM;
	assign regWrite = microState == cpuPkg::WRITEBACK && writesReg;
	assign outputStrobe = microState == cpuPkg::EXEC && isWwd;
	assign pcWrite = (microState == cpuPkg::EXEC && endsInExec) ||
		(microState == cpuPkg::MEM_WAIT && dataDone && opcode == isaPkg::OP_SWD) ||
		microState == cpuPkg::WRITEBACK;

	noWriteWhileHalted: assert property (@(posedge clk) disable iff (!reset_n)
		halted |-> !(regWrite || pcWrite || irWrite || outputStrobe || fetchStart || dataStart));

	legalState: assert property (@(posedge clk) disable iff (!reset_n)
		microState inside {cpuPkg::FETCH, cpuPkg::FETCH_WAIT, cpuPkg::DECODE, cpuPkg::EXEC,
			cpuPkg::MEM, cpuPkg::MEM_WAIT, cpuPkg::WRITEBACK});
endmodule

`default_nettype wire

// File: datapath/fetchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module fetchUnit (
	input wire clk,
	input wire reset_n,
	input wire fetchStart,
	input wire fetchDone,
	input wire irWrite,
	input wire pcWrite,
	input wire cpuPkg::pcSrc_t pcSrc,
	input wire isaPkg::word_t regValue,
	input wire isaPkg::word_t readData,
	output logic fetchReq,
	output isaPkg::word_t pc,
	output isaPkg::word_t instruction
);
	isaPkg::word_t ir, pcNext, pcPlusOne;
	logic irLoad;

	assign irLoad = irWrite && fetchDone;
	// fresh word visible in the done cycle so jumps decode early
	assign instruction = irLoad ? readData : ir;
	assign pcPlusOne = pc + 16'd1;

	always_comb begin
		case (pcSrc)
			cpuPkg::PC_BRANCH: pcNext = pcPlusOne + isaPkg::signExtend8(isaPkg::imm8Field(ir));
			cpuPkg::PC_JUMP: pcNext = {pc[15:12], isaPkg::target12Field(ir)};
			cpuPkg::PC_REG: pcNext = regValue;
			default: pcNext = pcPlusOne;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
			fetchReq <= 1'b0;
		end else begin
			if (fetchStart)
				fetchReq <= 1'b1;
			else if (fetchDone)
				fetchReq <= 1'b0;
			if (pcWrite)
				pc <= pcNext;
		end
	end

	always_ff @(posedge clk) begin
		if (irLoad)
			ir <= readData;
	end
endmodule

`default_nettype wire

// File: datapath/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath (
	input wire clk,
	input wire reset_n,
	input wire isaPkg::word_t instruction,
	input wire isaPkg::word_t pc,
	input wire cpuPkg::microState_t microState,
	input wire isaPkg::aluOp_t aluOp,
	input wire aluSrcImm,
	input wire regWrite,
	input wire cpuPkg::wbSel_t wbSel,
	input wire cpuPkg::dstSel_t dstSel,
	input wire outputStrobe,
	input wire dataStart,
	input wire dataDone,
	input wire isaPkg::word_t readData,
	output logic dataReq,
	output logic dataWrite,
	output isaPkg::word_t dataAddr,
	output isaPkg::word_t dataWdata,
	output logic branchTaken,
	output isaPkg::word_t regValue,
	output isaPkg::word_t outputPort,
	output logic outputValid
);
	isaPkg::word_t regs [4];
	isaPkg::word_t rsValue, rtValue, immValue, aluB, aluOut;
	isaPkg::word_t result, memData, wbValue;
	isaPkg::opcode_t opcode;
	isaPkg::regIdx_t dstIdx;
	logic [7:0] imm8;

	assign opcode = isaPkg::opcodeField(instruction);
	assign imm8 = isaPkg::imm8Field(instruction);
	assign rsValue = regs[isaPkg::rsField(instruction)];
	assign rtValue = regs[isaPkg::rtField(instruction)];

	// ori takes its immediate unsigned
	assign immValue = (opcode == isaPkg::OP_ORI) ? {8'h00, imm8} : isaPkg::signExtend8(imm8);
	assign aluB = aluSrcImm ? immValue : rtValue;

	always_comb begin
		case (aluOp)
			isaPkg::ALU_ADD: aluOut = rsValue + aluB;
			isaPkg::ALU_SUB: aluOut = rsValue - aluB;
			isaPkg::ALU_AND: aluOut = rsValue & aluB;
			isaPkg::ALU_OR: aluOut = rsValue | aluB;
			isaPkg::ALU_NOT: aluOut = ~rsValue;
			isaPkg::ALU_TCP: aluOut = ~rsValue + 16'd1;
			isaPkg::ALU_ALS: aluOut = rsValue << 1;
			isaPkg::ALU_ARS: aluOut = $signed(rsValue) >>> 1;
			default: aluOut = '0;
		endcase
	end

	always_comb begin
		case (opcode)
			isaPkg::OP_BNE: branchTaken = rsValue != rtValue;
			isaPkg::OP_BEQ: branchTaken = rsValue == rtValue;
			isaPkg::OP_BGZ: branchTaken = $signed(rsValue) > 16'sd0;
			isaPkg::OP_BLZ: branchTaken = rsValue[15];   // sign bit
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		case (dstSel)
			cpuPkg::DST_RT: dstIdx = isaPkg::rtField(instruction);
			cpuPkg::DST_R2: dstIdx = 2'd2;
			default: dstIdx = isaPkg::rdField(instruction);
		endcase
	end

	always_comb begin
		case (wbSel)
			cpuPkg::WB_MEMORY: wbValue = memData;
			cpuPkg::WB_LINK: wbValue = pc + 16'd1;   // pc not yet advanced in writeback
			cpuPkg::WB_UPPER: wbValue = {imm8, 8'h00};
			default: wbValue = result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			regs <= '{default: '0};
		else if (regWrite)
			regs[dstIdx] <= wbValue;
	end

	always_ff @(posedge clk) begin
		if (microState == cpuPkg::EXEC)
			result <= aluOut;
		if (dataDone)
			memData <= readData;
		if (outputStrobe)
			outputPort <= rsValue;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			dataReq <= 1'b0;
			outputValid <= 1'b0;
		end else begin
			if (dataStart)
				dataReq <= 1'b1;
			else if (dataDone)
				dataReq <= 1'b0;
			outputValid <= outputStrobe;
		end
	end

	assign dataAddr = result;   // rs + imm from exec
	assign dataWdata = rtValue;
	assign dataWrite = opcode == isaPkg::OP_SWD;
	assign regValue = rsValue;

	noDataReqInFetch: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(dataReq) |-> !(microState inside {cpuPkg::FETCH, cpuPkg::FETCH_WAIT}));
endmodule

`default_nettype wire

// File: hw/memArbiter.sv
`timescale 1ns/100ps
`default_nettype none

module memArbiter (
	input wire clk,
	input wire reset_n,
	input wire fetchReq,
	input wire dataReq,
	input wire dataWrite,
	input wire isaPkg::word_t fetchAddr,
	input wire isaPkg::word_t dataAddr,
	input wire isaPkg::word_t dataWdata,
	input wire isaPkg::word_t memRdata,
	input wire memDone,
	output logic memReq,
	output logic memWrite,
	output isaPkg::word_t memAddr,
	output isaPkg::word_t memWdata,
	output isaPkg::word_t readData,
	output logic fetchDone,
	output logic dataDone
);
	logic busy, dataOwner, dataSel;

	assign dataSel = busy ? dataOwner : dataReq;   // data wins a tie
	assign memReq = busy || fetchReq || dataReq;
	assign memAddr = dataSel ? dataAddr : fetchAddr;
	assign memWrite = dataSel && dataWrite;
	assign memWdata = dataWdata;
	assign readData = memRdata;
	assign fetchDone = memDone && !dataSel;
	assign dataDone = memDone && dataSel;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy <= 1'b0;
			dataOwner <= 1'b0;
		end else begin
			busy <= memReq && !memDone;
			if (!busy)
				dataOwner <= dataReq;   // owner fixed until done
		end
	end

	doneOnlyWithReq: assert property (@(posedge clk) disable iff (!reset_n)
		memDone |-> memReq);
endmodule

`default_nettype wire

// File: hw/cpuTop.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTop (
	input wire clk,
	input wire reset_n,
	output logic memReq,
	output logic memWrite,
	output isaPkg::word_t memAddr,
	output isaPkg::word_t memWdata,
	input wire isaPkg::word_t memRdata,
	input wire memDone,
	output isaPkg::word_t outputPort,
	output logic outputValid,
	output isaPkg::word_t numInst,
	output logic halted
);
	cpuPkg::microState_t microState;
	isaPkg::aluOp_t aluOp;
	cpuPkg::wbSel_t wbSel;
	cpuPkg::dstSel_t dstSel;
	cpuPkg::pcSrc_t pcSrc;
	logic aluSrcImm, regWrite, pcWrite, irWrite;
	logic fetchStart, dataStart, outputStrobe, branchTaken;
	logic fetchReq, fetchDone, dataReq, dataWrite, dataDone;
	isaPkg::word_t instruction, pc, regValue, readData, dataAddr, dataWdata;

	controlUnit control (
		.clk(clk), .reset_n(reset_n), .instruction(instruction),
		.fetchDone(fetchDone), .dataDone(dataDone), .branchTaken(branchTaken),
		.microState(microState), .aluOp(aluOp), .aluSrcImm(aluSrcImm),
		.regWrite(regWrite), .wbSel(wbSel), .dstSel(dstSel), .pcSrc(pcSrc),
		.pcWrite(pcWrite), .irWrite(irWrite), .fetchStart(fetchStart),
		.dataStart(dataStart), .outputStrobe(outputStrobe),
		.numInst(numInst), .halted(halted)
	);

	fetchUnit fetch (
		.clk(clk), .reset_n(reset_n), .fetchStart(fetchStart), .fetchDone(fetchDone),
		.irWrite(irWrite), .pcWrite(pcWrite), .pcSrc(pcSrc), .regValue(regValue),
		.readData(readData), .fetchReq(fetchReq), .pc(pc), .instruction(instruction)
	);

	datapath dp (
		.clk(clk), .reset_n(reset_n), .instruction(instruction), .pc(pc),
		.microState(microState), .aluOp(aluOp), .aluSrcImm(aluSrcImm),
		.regWrite(regWrite), .wbSel(wbSel), .dstSel(dstSel),
		.outputStrobe(outputStrobe), .dataStart(dataStart), .dataDone(dataDone),
		.readData(readData), .dataReq(dataReq), .dataWrite(dataWrite),
		.dataAddr(dataAddr), .dataWdata(dataWdata), .branchTaken(branchTaken),
		.regValue(regValue), .outputPort(outputPort), .outputValid(outputValid)
	);

	// single external port shared by fetch and load/store
	memArbiter arbiter (
		.clk(clk), .reset_n(reset_n), .fetchReq(fetchReq), .dataReq(dataReq),
		.dataWrite(dataWrite), .fetchAddr(pc), .dataAddr(dataAddr),
		.dataWdata(dataWdata), .memRdata(memRdata), .memDone(memDone),
		.memReq(memReq), .memWrite(memWrite), .memAddr(memAddr),
		.memWdata(memWdata), .readData(readData),
		.fetchDone(fetchDone), .dataDone(dataDone)
	);
endmodule

`default_nettype wire

// File: test/cpuTb.sv
`timescale 1ns/100ps
`default_nettype none

module cpuTb;
	localparam int PROG_LEN = 63;   // highest program address plus one
	localparam int TIMEOUT_CYCLES = PROG_LEN * 20;
	localparam int NUM_OUT = 19;
	localparam logic [7:0] STORE_ADDR = 8'h70;

	logic clk, reset_n;
	logic memReq, memWrite, memDone, outputValid, halted;
	isaPkg::word_t memAddr, memWdata, memRdata, outputPort, numInst;

	isaPkg::word_t memory [256];
	isaPkg::word_t expectedOut [NUM_OUT];
	int outIdx, cycleCount;

	// memory model state
	logic memBusy, reqWrite;
	isaPkg::word_t reqAddr, reqData;
	int latency;

	cpuTop UUT (
		.clk(clk), .reset_n(reset_n),
		.memReq(memReq), .memWrite(memWrite), .memAddr(memAddr), .memWdata(memWdata),
		.memRdata(memRdata), .memDone(memDone),
		.outputPort(outputPort), .outputValid(outputValid),
		.numInst(numInst), .halted(halted)
	);

	always #50 clk = ~clk;

	function automatic isaPkg::word_t immInstr(isaPkg::opcode_t op, isaPkg::regIdx_t rs,
		isaPkg::regIdx_t rt, logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic isaPkg::word_t rInstr(isaPkg::regIdx_t rs, isaPkg::regIdx_t rt,
		isaPkg::regIdx_t rd, isaPkg::func_t func);
		return {isaPkg::OP_RTYPE, rs, rt, rd, func};
	endfunction

	function automatic isaPkg::word_t jumpInstr(isaPkg::opcode_t op, logic [11:0] target);
		return {op, target};
	endfunction

	task automatic stopWithFail();
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic checkValue(string name, isaPkg::word_t actual, isaPkg::word_t expected);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
			stopWithFail();
		end
	endtask

	task automatic loadProgram();
		int a;
		for (a = 0; a < 256; a++)
			memory[a] = {~a[7:0], a[7:0]};
		memory[0] = immInstr(isaPkg::OP_LHI, 2'd0, 2'd1, 8'h12);   // r1 = 0x1200
		memory[1] = immInstr(isaPkg::OP_ORI, 2'd1, 2'd1, 8'h34);   // r1 = 0x1234
		memory[2] = immInstr(isaPkg::OP_ADI, 2'd0, 2'd2, 8'h9c);   // r2 = -100
		memory[3] = immInstr(isaPkg::OP_ORI, 2'd0, 2'd3, 8'h85);   // no sign extension
		memory[4] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[5] = rInstr(2'd1, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[6] = rInstr(2'd2, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[7] = rInstr(2'd1, 2'd2, 2'd3, isaPkg::FUNC_ADD);
		memory[8] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[9] = rInstr(2'd1, 2'd2, 2'd3, isaPkg::FUNC_SUB);
		memory[10] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[11] = rInstr(2'd1, 2'd2, 2'd3, isaPkg::FUNC_AND);
		memory[12] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[13] = rInstr(2'd1, 2'd2, 2'd3, isaPkg::FUNC_ORR);
		memory[14] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[15] = rInstr(2'd1, 2'd0, 2'd3, isaPkg::FUNC_NOT);
		memory[16] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[17] = rInstr(2'd1, 2'd0, 2'd3, isaPkg::FUNC_TCP);
		memory[18] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[19] = rInstr(2'd2, 2'd0, 2'd3, isaPkg::FUNC_SHL);
		memory[20] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[21] = rInstr(2'd2, 2'd0, 2'd3, isaPkg::FUNC_SHR);
		memory[22] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[23] = immInstr(isaPkg::OP_SWD, 2'd0, 2'd1, STORE_ADDR);
		memory[24] = immInstr(isaPkg::OP_LWD, 2'd0, 2'd3, STORE_ADDR);
		memory[25] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		// each taken branch skips a WWD of r0 that the table never expects
		memory[26] = immInstr(isaPkg::OP_BNE, 2'd1, 2'd2, 8'h01);   // taken
		memory[27] = rInstr(2'd0, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[28] = immInstr(isaPkg::OP_BNE, 2'd1, 2'd3, 8'h01);   // not taken
		memory[29] = rInstr(2'd2, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[30] = immInstr(isaPkg::OP_BEQ, 2'd1, 2'd3, 8'h01);   // taken
		memory[31] = rInstr(2'd0, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[32] = immInstr(isaPkg::OP_BEQ, 2'd1, 2'd2, 8'h01);   // not taken
		memory[33] = rInstr(2'd1, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[34] = immInstr(isaPkg::OP_BGZ, 2'd1, 2'd0, 8'h01);   // taken
		memory[35] = rInstr(2'd0, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[36] = immInstr(isaPkg::OP_BGZ, 2'd0, 2'd0, 8'h01);   // r0 is zero so not taken
		memory[37] = rInstr(2'd2, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[38] = immInstr(isaPkg::OP_BLZ, 2'd2, 2'd0, 8'h01);   // taken
		memory[39] = rInstr(2'd0, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[40] = immInstr(isaPkg::OP_BLZ, 2'd0, 2'd0, 8'h01);   // r0 is zero so not taken
		memory[41] = rInstr(2'd1, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[42] = jumpInstr(isaPkg::OP_JMP, 12'd45);
		memory[43] = rInstr(2'd0, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[44] = rInstr(2'd0, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[45] = jumpInstr(isaPkg::OP_JAL, 12'd50);   // r2 = 46
		memory[46] = immInstr(isaPkg::OP_ADI, 2'd0, 2'd3, 8'd60);
		memory[47] = rInstr(2'd3, 2'd0, 2'd0, isaPkg::FUNC_JRL);   // r2 = 48
		memory[48] = rInstr(2'd1, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[49] = rInstr(2'd0, 2'd0, 2'd0, isaPkg::FUNC_HLT);
		memory[50] = rInstr(2'd2, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[51] = rInstr(2'd2, 2'd0, 2'd0, isaPkg::FUNC_JPR);   // back to 46
		memory[60] = rInstr(2'd2, 2'd0, 2'd0, isaPkg::FUNC_WWD);
		memory[61] = immInstr(isaPkg::OP_ORI, 2'd0, 2'd1, 8'h77);
		memory[62] = rInstr(2'd2, 2'd0, 2'd0, isaPkg::FUNC_JPR);   // back to 48
	endtask

	// memory with 1 to 3 cycles of latency per request
	always @(posedge clk) begin
		#1;
		memDone = 1'b0;
		if (!reset_n) begin
			memBusy = 1'b0;
		end else if (memBusy) begin
			latency = latency - 1;
			if (latency == 0) begin
				if (reqWrite)
					memory[reqAddr[7:0]] = reqData;
				else
					memRdata = memory[reqAddr[7:0]];
				memDone = 1'b1;
				memBusy = 1'b0;
			end
		end else if (memReq) begin
			memBusy = 1'b1;
			latency = $urandom_range(3, 1);
			reqAddr = memAddr;
			reqWrite = memWrite;
			reqData = memWdata;
		end
	end

	// output checks and a frozen core once halted
	always @(posedge clk) begin
		#1;
		if (reset_n && outputValid) begin
			if (outIdx >= NUM_OUT) begin
				$display("unexpected WWD output %h at %0t ns beyond the expected list",
					outputPort, $time);
				stopWithFail();
			end else begin
				checkValue("outputPort", outputPort, expectedOut[outIdx]);
				outIdx++;
			end
		end
		if (halted === 1'b1) begin
			checkValue("memReq", 16'(memReq), 16'd0);
			checkValue("outputValid", 16'(outputValid), 16'd0);
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stopWithFail();
		end
	end

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		memDone = 1'b0;
		memRdata = '0;
		memBusy = 1'b0;
		outIdx = 0;
		cycleCount = 0;
		void'($urandom(32'hbc9c_2c9b));
		loadProgram();
		expectedOut = '{16'h0085, 16'h1234, 16'hff9c, 16'h11d0, 16'h1298, 16'h1214,
			16'hffbc, 16'hedcb, 16'hedcc, 16'hff38, 16'hffce, 16'h1234, 16'hff9c,
			16'h1234, 16'hff9c, 16'h1234, 16'h002e, 16'h0030, 16'h0077};
		repeat (4) @(posedge clk);
		#1 reset_n = 1'b1;
		wait (halted === 1'b1);
		repeat (20) @(posedge clk);   // core must stay quiet
		#2;
		checkValue("output count", 16'(outIdx), 16'(NUM_OUT));
		checkValue("numInst", numInst, 16'd48);   // 49 instructions incl. HLT
		checkValue("memory[0x70]", memory[STORE_ADDR], 16'h1234);
		$display("Finished with no errors");
		$finish;
	end
endmodule

`default_nettype wire

// File: compile.f
common/isaPkg.sv
common/cpuPkg.sv
control/controlUnit.sv
datapath/fetchUnit.sv
datapath/datapath.sv
hw/memArbiter.sv
hw/cpuTop.sv
test/cpuTb.sv

// File: Bender.yml
package:
  name: cpu16

sources:
  - common/isaPkg.sv
  - common/cpuPkg.sv
  - control/controlUnit.sv
  - datapath/fetchUnit.sv
  - datapath/datapath.sv
  - hw/memArbiter.sv
  - hw/cpuTop.sv
  - target: test
    files:
      - test/cpuTb.sv
